/* bench/eth_frame_loop_tb.sv */
// loopback testbench: sends a table of ethernet frames through the DUT and checks every output byte
`timescale 1ns/100ps

module eth_frame_loop_tb import crc32_pkg::*, eth_frame_pkg::*; ();

	localparam int NUM_CASES = 12;
	localparam int BYTE_TIMEOUT = 5000; // cycles one input byte may wait for tready
	localparam int DRAIN_TIMEOUT = 20000;

	// one table row, stimulus first and the expected drop decision last
	typedef struct packed {
		logic [15:0] len;
		logic ip;
		logic bad_csum;
		logic bad_fcs;
		logic regen;
		logic rnd_ready;
		logic drop;
	} frame_case_t;

	logic clk, rst_n;
	logic [7:0] s_axis_tdata;
	logic s_axis_tlast, s_axis_tvalid, s_axis_tready;
	logic [7:0] m_axis_tdata;
	logic m_axis_tuser, m_axis_tlast, m_axis_tvalid, m_axis_tready;
	logic fcs_regen;
	logic [3:0] corrupt_every;

	frame_case_t cases [NUM_CASES];
	logic [7:0] tx_buf [256];
	logic [7:0] out_buf [256];
	logic [7:0] exp_data [$]; // expected output bytes of all pending frames
	logic exp_user [$];
	logic exp_last [$];
	int exp_id [$];
	logic exp_mode [$]; // random tready while this frame comes out
	int seed, ready_seed;
	int errors, frame_errs, beat_idx, kept_cnt, checked, dropped;
	bit timed_out;

	eth_frame_loop #(.FRAME_DEPTH(256), .CTL_DEPTH(4)) eth_frame_loop_i (
		.clk, .rst_n,
		.s_axis_tdata, .s_axis_tlast, .s_axis_tvalid, .s_axis_tready,
		.m_axis_tdata, .m_axis_tuser, .m_axis_tlast, .m_axis_tvalid, .m_axis_tready,
		.fcs_regen, .corrupt_every
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ones-complement sum of the ten IPv4 header words with the checksum word left out
	function automatic logic [15:0] header_sum(input logic [7:0] b [256]);
		logic [16:0] acc;
		acc = '0;
		for (int w = 7; w < 17; w++) begin
			if (w != 12) begin
				acc = acc + {1'b0, b[2*w], b[2*w+1]};
				acc = {1'b0, acc[15:0]} + {16'd0, acc[16]};
			end
		end
		return acc[15:0];
	endfunction

	function automatic logic [31:0] crc_run(input logic [7:0] b [256], input int n);
		logic [31:0] c;
		c = CRC32_INIT;
		for (int i = 0; i < n; i++) begin
			c = c ^ {24'd0, b[i]};
			for (int k = 0; k < 8; k++) c = c[0] ? (c >> 1) ^ CRC32_POLY_REFLECTED : c >> 1;
		end
		return c;
	endfunction

	task automatic build_frame(input frame_case_t fc);
		logic [15:0] csum;
		logic [31:0] fcs;
		for (int j = 0; j < fc.len; j++) tx_buf[j] = 8'($random(seed));
		{tx_buf[12], tx_buf[13]} = fc.ip ? ETHERTYPE_IPV4 : 16'h88B5;
		if (fc.ip) begin
			tx_buf[14] = 8'h45;
			csum = ~header_sum(tx_buf);
			if (fc.bad_csum) csum = csum ^ 16'h5A5A;
			{tx_buf[24], tx_buf[25]} = csum;
		end
		fcs = ~crc_run(tx_buf, fc.len - 4); // low byte goes out first
		{tx_buf[fc.len-1], tx_buf[fc.len-2], tx_buf[fc.len-3], tx_buf[fc.len-4]} = fcs;
		if (fc.bad_fcs) tx_buf[fc.len-1] = tx_buf[fc.len-1] ^ 8'h01;
	endtask

	// expected output from the drop, checksum, FCS and corrupt rules
	task automatic predict_frame(input int idx, input frame_case_t fc, output logic drop);
		logic corrupt;
		logic [15:0] csum;
		logic [31:0] fcs;
		int n;
		n = fc.len;
		drop = (crc_run(tx_buf, n) != CRC32_RESIDUE) || (n < MIN_FRAME_LEN);
		if (drop != fc.drop) begin
			errors++;
			$display("frame %0d: the model's drop decision disagrees with the table", idx);
		end
		if (drop) begin
			dropped++;
		end else begin
			for (int j = 0; j < n; j++) out_buf[j] = tx_buf[j];
			if ({out_buf[12], out_buf[13]} == ETHERTYPE_IPV4 && out_buf[14] == 8'h45) begin
				csum = ~header_sum(out_buf);
				if (csum != 16'd0) {out_buf[24], out_buf[25]} = csum; // zero keeps the original
			end
			if (fc.regen) begin
				fcs = ~crc_run(out_buf, n - 4);
				{out_buf[n-1], out_buf[n-2], out_buf[n-3], out_buf[n-4]} = fcs;
			end
			kept_cnt++;
			corrupt = (corrupt_every != 4'd0) && (kept_cnt % int'(corrupt_every) == 0);
			for (int j = 0; j < n; j++) begin
				exp_data.push_back(out_buf[j]);
				exp_user.push_back(corrupt && j == n - 1);
				exp_last.push_back(j == n - 1);
			end
			exp_id.push_back(idx);
			exp_mode.push_back(fc.rnd_ready);
		end
	endtask

	task automatic send_frame(input int len);
		int cnt;
		logic took;
		for (int j = 0; j < len && !timed_out; j++) begin
			s_axis_tdata = tx_buf[j];
			s_axis_tlast = (j == len - 1);
			s_axis_tvalid = 1'b1;
			took = 1'b0;
			cnt = 0;
			while (!took && !timed_out) begin
				@(negedge clk);
				took = s_axis_tready; // tready settles well before the next edge
				@(posedge clk);
				#1;
				cnt++;
				if (!took && cnt >= BYTE_TIMEOUT) begin
					timed_out = 1'b1;
					$display("timeout: input byte %0d was never accepted", j);
				end
			end
		end
		s_axis_tvalid = 1'b0;
		s_axis_tlast = 1'b0;
	endtask

	task automatic compare_value(input string name, input logic [7:0] expv, input logic [7:0] actv);
		if (actv !== expv) begin
			frame_errs++;
			$display("[FAIL] frame %0d byte %0d %s expected 0x%02h actual 0x%02h",
				exp_id[0], beat_idx, name, expv, actv);
		end
	endtask

	task automatic check_beat();
		logic last;
		if (exp_data.size() == 0) begin
			errors++;
			$display("output byte 0x%02h came out while no frame was expected", m_axis_tdata);
		end else begin
			last = exp_last.pop_front();
			compare_value("m_axis_tdata", exp_data.pop_front(), m_axis_tdata);
			compare_value("m_axis_tuser", {7'd0, exp_user.pop_front()}, {7'd0, m_axis_tuser});
			compare_value("m_axis_tlast", {7'd0, last}, {7'd0, m_axis_tlast});
			beat_idx++;
			if (last) begin
				$display("frame %0d: %0d bytes out, %0d errors", exp_id[0], beat_idx, frame_errs);
				errors += frame_errs;
				frame_errs = 0;
				beat_idx = 0;
				checked++;
				exp_id.delete(0);
				exp_mode.delete(0);
			end
		end
	endtask

	initial begin
		forever begin
			@(negedge clk);
			if (rst_n && m_axis_tvalid && m_axis_tready) check_beat();
		end
	end

	initial begin
		m_axis_tready = 1'b0;
		ready_seed = 96;
		forever begin
			@(posedge clk);
			#1;
			if (exp_mode.size() != 0 && exp_mode[0]) m_axis_tready = 1'($random(ready_seed));
			else m_axis_tready = 1'b1;
		end
	end

	initial begin
		int cnt;
		logic drop;
		rst_n = 1'b0;
		s_axis_tdata = 8'h00;
		s_axis_tlast = 1'b0;
		s_axis_tvalid = 1'b0;
		fcs_regen = 1'b0;
		corrupt_every = 4'd3;
		seed = 96;
		{errors, frame_errs, beat_idx, kept_cnt, checked, dropped} = '0;
		timed_out = 1'b0;
		// len, ip, bad_csum, bad_fcs, regen, random tready, expected drop
		cases = '{
			'{16'd64, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0},
			'{16'd90, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0},
			'{16'd80, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0},
			'{16'd70, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1},
			'{16'd40, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1},
			'{16'd64, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0},
			'{16'd100, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0},
			'{16'd128, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0},
			'{16'd63, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1},
			'{16'd200, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0},
			'{16'd66, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1},
			'{16'd96, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0}
		};
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// frames go in back to back, the next one starts on the clock after tlast
		for (int i = 0; i < NUM_CASES && !timed_out; i++) begin
			build_frame(cases[i]);
			predict_frame(i, cases[i], drop);
			fcs_regen = cases[i].regen;
			send_frame(cases[i].len);
			if (drop) $display("frame %0d: %0d bytes in, dropped, no output expected", i, cases[i].len);
		end

		cnt = 0;
		while (exp_data.size() != 0 && !timed_out) begin
			@(posedge clk);
			cnt++;
			if (cnt >= DRAIN_TIMEOUT) begin
				timed_out = 1'b1;
				$display("timeout: %0d expected output bytes never came out", exp_data.size());
			end
		end
		cnt = 0;
		while (cnt < 100 && !timed_out) begin // stray bytes of dropped frames would show up here
			@(posedge clk);
			cnt++;
		end

		errors += frame_errs;
		$display("frames %0d, checked %0d, dropped %0d, errors %0d", NUM_CASES, checked, dropped, errors);
		if (errors == 0 && !timed_out) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds the loopback testbench with Verilator, runs it and judges the log
cd "$(dirname "$0")" || exit 1
set -o pipefail
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module eth_frame_loop_tb \
	-o eth_frame_loop_sim \
	&& ./obj_dir/eth_frame_loop_sim 2>&1 | tee sim.log \
	|| { echo "build or simulation failed"; exit 1; }

grep -q ">>> FAIL" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

/* source/crc32_byte.sv */
// CRC-32 byte step: advances a reflected ethernet CRC state by one data byte
`timescale 1ns/100ps

module crc32_byte import crc32_pkg::*; (
	input logic [31:0] state_in,
	input logic [7:0] data_in,
	output logic [31:0] state_out
);

	logic [31:0] crc_work;

	// the byte enters LSB first, as it goes on the wire
	always_comb begin
		crc_work = state_in;

		for (int i = 0; i < 8; i++) begin
			if (crc_work[0] ^ data_in[i]) begin
				crc_work = (crc_work >> 1) ^ CRC32_POLY_REFLECTED;
			end else begin
				crc_work = crc_work >> 1;
			end
		end

		state_out = crc_work; // no final inversion here, the callers do it
	end

endmodule

/* source/crc32_pkg.sv */
// CRC-32 package: polynomial, initial state and check residue of the ethernet FCS
package crc32_pkg;

	// IEEE 802.3 polynomial 0x04C11DB7 in bit reversed form, for an LSB first register
	localparam logic [31:0] CRC32_POLY_REFLECTED = 32'hEDB88320;

	// the register starts at all ones for every frame
	localparam logic [31:0] CRC32_INIT = 32'hFFFFFFFF;

	// state left in the register after a frame and its correct FCS have passed through,
	// so a receiver checks a frame without knowing where the FCS starts
	localparam logic [31:0] CRC32_RESIDUE = 32'hDEBB20E3;

endpackage

/* source/eth_frame_classify.sv */
// frame classifier: buffers the incoming frame, checks FCS and length, works out the IPv4 checksum
`timescale 1ns/100ps

module eth_frame_classify import eth_frame_pkg::*, crc32_pkg::*; #(
	parameter int FRAME_DEPTH = 2048
) (
	input logic clk,
	input logic rst_n,

	input logic [7:0] s_axis_tdata,
	input logic s_axis_tlast,
	input logic s_axis_tvalid,
	output logic s_axis_tready,

	input logic fcs_regen,
	input logic [3:0] corrupt_every,

	output frame_beat_t beat_data,
	output logic beat_valid,
	input logic beat_ready,

	output loop_ctl_t ctl_data,
	output logic ctl_valid,
	input logic ctl_ready
);

	logic in_enable; // low in reset and for one clock after it
	logic [3:0][7:0] pipe_data; // index 0 holds the newest byte
	logic [3:0] pipe_vld;
	logic draining;
	logic adv, s_fire, drain_step, drain_done, shift;

	logic [15:0] byte_cnt; // bytes already accepted in this frame
	logic [14:0] word_idx;
	logic [31:0] crc_state, crc_next;
	logic [15:0] csum_acc, csum_next;
	logic [16:0] csum_sum;
	logic hdr_word;
	logic [15:0] ethertype;
	logic [7:0] ver_ihl;
	logic [3:0] keep_cnt; // frames kept since the last corrupt mark
	logic frame_drop, frame_corrupt;

	always_comb begin
		// the output stage moves when neither the beat nor the control word is stuck
		adv = (!beat_valid || beat_ready) && (!ctl_valid || ctl_ready);
		s_axis_tready = in_enable && !draining && adv && ctl_ready;
		s_fire = s_axis_tvalid && s_axis_tready;

		drain_step = draining && adv && ctl_ready;
		drain_done = drain_step && (pipe_vld[2:0] == 3'b000); // last held byte leaves
		shift = s_fire || drain_step;

		// header words pair the previous byte with the current one
		word_idx = byte_cnt[15:1];
		hdr_word = byte_cnt[0] && (word_idx >= IP_HDR_POS / 2) &&
			(word_idx < IP_HDR_POS / 2 + IP_HDR_WORDS) && (word_idx != IP_CSUM_WORD);
		csum_sum = {1'b0, csum_acc} + {1'b0, pipe_data[0], s_axis_tdata};
		csum_next = hdr_word ? csum_sum[15:0] + {15'd0, csum_sum[16]} : csum_acc;

		frame_drop = (crc_next != CRC32_RESIDUE) || (byte_cnt < 16'(MIN_FRAME_LEN - 1));
		frame_corrupt = !frame_drop && (corrupt_every != 4'd0) &&
			(keep_cnt + 4'd1 >= corrupt_every);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			in_enable <= 1'b0;
			pipe_vld <= '0;
			draining <= 1'b0;
			beat_valid <= 1'b0;
			ctl_valid <= 1'b0;
			byte_cnt <= '0;
			crc_state <= CRC32_INIT;
			csum_acc <= '0;
			keep_cnt <= '0;
		end else begin
			in_enable <= 1'b1;

			if (shift) begin
				pipe_vld <= {pipe_vld[2:0], s_fire};
				beat_valid <= pipe_vld[3]; // oldest byte drops into the output register
			end else if (beat_ready) begin
				beat_valid <= 1'b0;
			end

			if (s_fire && s_axis_tlast) draining <= 1'b1;
			else if (drain_done) draining <= 1'b0;

			// control word goes out alongside the last FCS byte
			if (drain_done) ctl_valid <= 1'b1;
			else if (ctl_ready) ctl_valid <= 1'b0;

			if (s_fire) begin
				if (s_axis_tlast) begin
					byte_cnt <= '0;
					crc_state <= CRC32_INIT;
					csum_acc <= '0;
					if (!frame_drop && corrupt_every != 4'd0) begin
						keep_cnt <= frame_corrupt ? 4'd0 : keep_cnt + 4'd1;
					end
				end else begin
					byte_cnt <= byte_cnt + 16'd1;
					crc_state <= crc_next;
					csum_acc <= csum_next;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (shift) begin
			pipe_data <= {pipe_data[2:0], s_axis_tdata};
			beat_data.data <= pipe_data[3];
			beat_data.tuser <= draining; // whatever is still held at tlast is FCS
			beat_data.tlast <= drain_done;
		end

		if (s_fire) begin
			if (byte_cnt == ETHERTYPE_POS) ethertype[15:8] <= s_axis_tdata;
			if (byte_cnt == ETHERTYPE_POS + 1) ethertype[7:0] <= s_axis_tdata;
			if (byte_cnt == IP_HDR_POS) ver_ihl <= s_axis_tdata;
		end

		if (s_fire && s_axis_tlast) begin
			ctl_data.update_fcs <= fcs_regen;
			ctl_data.ip_csum <= (ethertype == ETHERTYPE_IPV4 && ver_ihl == IPV4_VER_IHL) ?
				~csum_acc : 16'd0;
			ctl_data.drop <= frame_drop;
			ctl_data.corrupt <= frame_corrupt;
		end
	end

	crc32_byte crc32_byte_i (
		.state_in(crc_state),
		.data_in(s_axis_tdata),
		.state_out(crc_next)
	);

	// the whole frame has to fit the frame FIFO before its control word releases it
	a_frame_fits: assert property (@(posedge clk) disable iff (!rst_n)
		s_fire |-> byte_cnt < FRAME_DEPTH);

endmodule

/* source/eth_frame_loop.sv */
// ethernet loopback top: classifier, frame and control FIFOs, transmit stage
`timescale 1ns/100ps

module eth_frame_loop import eth_frame_pkg::*; #(
	parameter int FRAME_DEPTH = 2048,
	parameter int CTL_DEPTH = 4
) (
	input logic clk,
	input logic rst_n,

	input logic [7:0] s_axis_tdata,
	input logic s_axis_tlast,
	input logic s_axis_tvalid,
	output logic s_axis_tready,

	output logic [7:0] m_axis_tdata,
	output logic m_axis_tuser,
	output logic m_axis_tlast,
	output logic m_axis_tvalid,
	input logic m_axis_tready,

	input logic fcs_regen,
	input logic [3:0] corrupt_every
);

	frame_beat_t beat_wr, beat_rd;
	logic beat_wr_valid, beat_wr_ready, beat_rd_valid, beat_rd_ready;
	loop_ctl_t ctl_wr, ctl_rd;
	logic ctl_wr_valid, ctl_wr_ready, ctl_rd_valid, ctl_rd_ready;

	eth_frame_classify #(.FRAME_DEPTH(FRAME_DEPTH)) eth_frame_classify_i (
		.clk, .rst_n,
		.s_axis_tdata, .s_axis_tlast, .s_axis_tvalid, .s_axis_tready,
		.fcs_regen, .corrupt_every,
		.beat_data(beat_wr), .beat_valid(beat_wr_valid), .beat_ready(beat_wr_ready),
		.ctl_data(ctl_wr), .ctl_valid(ctl_wr_valid), .ctl_ready(ctl_wr_ready)
	);

	stream_fifo #(.payload_t(frame_beat_t), .DEPTH(FRAME_DEPTH)) frame_fifo_i (
		.clk, .rst_n,
		.wr_data(beat_wr), .wr_valid(beat_wr_valid), .wr_ready(beat_wr_ready),
		.rd_data(beat_rd), .rd_valid(beat_rd_valid), .rd_ready(beat_rd_ready)
	);

	stream_fifo #(.payload_t(loop_ctl_t), .DEPTH(CTL_DEPTH)) ctl_fifo_i (
		.clk, .rst_n,
		.wr_data(ctl_wr), .wr_valid(ctl_wr_valid), .wr_ready(ctl_wr_ready),
		.rd_data(ctl_rd), .rd_valid(ctl_rd_valid), .rd_ready(ctl_rd_ready)
	);

	eth_frame_loop_tx eth_frame_loop_tx_i (
		.clk, .rst_n,
		.s_axis_frame_tdata(beat_rd.data), .s_axis_frame_tuser(beat_rd.tuser),
		.s_axis_frame_tlast(beat_rd.tlast), .s_axis_frame_tvalid(beat_rd_valid),
		.s_axis_frame_tready(beat_rd_ready),
		.s_axis_ctl_tdata(ctl_rd), .s_axis_ctl_tvalid(ctl_rd_valid),
		.s_axis_ctl_tready(ctl_rd_ready),
		.m_axis_tdata, .m_axis_tuser, .m_axis_tlast, .m_axis_tvalid, .m_axis_tready
	);

endmodule

/* source/eth_frame_loop_tx.sv */
// loopback transmit stage: drops or sends each buffered frame as its control word says
`timescale 1ns/100ps

module eth_frame_loop_tx import eth_frame_pkg::*; (
	input logic clk,
	input logic rst_n,

	input logic [7:0] s_axis_frame_tdata,
	input logic s_axis_frame_tuser, // tags the four FCS bytes
	input logic s_axis_frame_tlast,
	input logic s_axis_frame_tvalid,
	output logic s_axis_frame_tready,

	input loop_ctl_t s_axis_ctl_tdata,
	input logic s_axis_ctl_tvalid,
	output logic s_axis_ctl_tready,

	output logic [7:0] m_axis_tdata,
	output logic m_axis_tuser,
	output logic m_axis_tlast,
	output logic m_axis_tvalid,
	input logic m_axis_tready
);

	typedef enum logic [1:0] {ST_WAIT, ST_SEND, ST_DROP} tx_state_t;

	tx_state_t state;
	loop_ctl_t ctl; // control word of the frame in flight
	logic [15:0] count; // output byte index within the frame
	logic [31:0] fcs_state, fcs_next;
	logic fcs_seen; // an FCS byte of this frame has already gone out
	logic ctl_fire, frame_fire;

	assign ctl_fire = s_axis_ctl_tvalid && s_axis_ctl_tready;
	assign frame_fire = s_axis_frame_tvalid && s_axis_frame_tready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_WAIT;
			s_axis_ctl_tready <= 1'b0;
			count <= '0;
			fcs_state <= '1;
			fcs_seen <= 1'b0;
		end else begin
			case (state)
				ST_WAIT: begin
					s_axis_ctl_tready <= 1'b1;
					if (ctl_fire) begin
						state <= s_axis_ctl_tdata.drop ? ST_DROP : ST_SEND;
						s_axis_ctl_tready <= 1'b0;
						count <= '0;
						fcs_state <= '1;
					end
				end

				ST_SEND: begin
					if (frame_fire) begin
						count <= count + 16'd1;
						// the CRC sees the bytes as sent, the FCS bytes shift the result out
						if (ctl.update_fcs) begin
							fcs_state <= s_axis_frame_tuser ? {8'hFF, fcs_state[31:8]} : fcs_next;
						end
						if (s_axis_frame_tlast) state <= ST_WAIT;
					end
				end

				ST_DROP: begin
					if (frame_fire && s_axis_frame_tlast) state <= ST_WAIT;
				end

				default: state <= ST_WAIT;
			endcase

			if (frame_fire && s_axis_frame_tlast) fcs_seen <= 1'b0;
			else if (state == ST_SEND && frame_fire && s_axis_frame_tuser) fcs_seen <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (ctl_fire) ctl <= s_axis_ctl_tdata;
	end

	always_comb begin
		m_axis_tdata = s_axis_frame_tdata;
		m_axis_tuser = 1'b0;
		m_axis_tlast = 1'b0;
		m_axis_tvalid = 1'b0;
		s_axis_frame_tready = 1'b0;

		if (state == ST_SEND) begin
			if (ctl.update_fcs && s_axis_frame_tuser) begin
				m_axis_tdata = ~fcs_state[7:0]; // low byte first
			end else if (ctl.ip_csum != 16'd0 && count[15:1] == IP_CSUM_WORD) begin
				m_axis_tdata = count[0] ? ctl.ip_csum[7:0] : ctl.ip_csum[15:8];
			end

			m_axis_tuser = ctl.corrupt && s_axis_frame_tlast; // receiver sees a bad frame
			m_axis_tlast = s_axis_frame_tlast;
			m_axis_tvalid = s_axis_frame_tvalid;
			s_axis_frame_tready = m_axis_tready;
		end else if (state == ST_DROP) begin
			s_axis_frame_tready = 1'b1;
		end
	end

	crc32_byte crc32_byte_i (
		.state_in(fcs_state),
		.data_in(m_axis_tdata),
		.state_out(fcs_next)
	);

	// the classifier tags only the trailing bytes, so once FCS starts it runs to tlast
	a_fcs_tail: assert property (@(posedge clk) disable iff (!rst_n)
		state == ST_SEND && fcs_seen && s_axis_frame_tvalid |-> s_axis_frame_tuser);

endmodule

/* source/eth_frame_pkg.sv */
// ethernet frame package: frame layout constants and the classifier to transmit control word
package eth_frame_pkg;

	// one buffered byte as it sits in the frame FIFO
	typedef struct packed {
		logic [7:0] data;
		logic tuser; // set on the four FCS bytes
		logic tlast;
	} frame_beat_t;

	// one control word per frame, written by the classifier after the last FCS byte
	typedef struct packed {
		logic update_fcs; // regenerate the FCS over the outgoing bytes
		logic [15:0] ip_csum; // zero leaves the IPv4 header checksum as it is
		logic drop;
		logic corrupt; // raise tuser on the last output byte
	} loop_ctl_t;

	localparam int ETHERTYPE_POS = 12; // byte offset of the ethertype, no VLAN tag
	localparam int IP_HDR_POS = 14; // first byte of the IPv4 header
	localparam int IP_HDR_WORDS = 10; // header length 5, no options

	// 16-bit word index of the IPv4 header checksum, bytes 24 and 25
	localparam int IP_CSUM_WORD = 12;

	localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
	localparam logic [7:0] IPV4_VER_IHL = 8'h45; // version 4, header length 5

	// shortest legal frame in bytes, FCS included
	localparam int MIN_FRAME_LEN = 64;

endpackage

/* source/stream_fifo.sv */
// stream FIFO that shows its head entry without a read request and carries any payload type
`timescale 1ns/100ps

module stream_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 16 // must be a power of two, at least 2
) (
	input logic clk,
	input logic rst_n,

	input payload_t wr_data,
	input logic wr_valid,
	output logic wr_ready,

	output payload_t rd_data,
	output logic rd_valid,
	input logic rd_ready
);

	localparam int AW = $clog2(DEPTH);

	payload_t mem [DEPTH];

	logic [AW:0] wr_ptr, rd_ptr; // one extra bit tells full from empty
	logic full, empty;
	logic wr_fire, rd_fire;

	always_comb begin
		full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
		empty = (wr_ptr == rd_ptr);

		wr_ready = ~full;
		rd_valid = ~empty;
		rd_data = mem[rd_ptr[AW-1:0]]; // head entry is shown without a read request

		wr_fire = wr_valid && wr_ready;
		rd_fire = rd_valid && rd_ready;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_fire) wr_ptr <= wr_ptr + 1'b1;
			if (rd_fire) rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire) mem[wr_ptr[AW-1:0]] <= wr_data;
	end

	// a stalled head entry stays on offer and is never overwritten until it is read
	a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rd_valid && !rd_ready |=> rd_valid && $stable(rd_data));

	// a writer that meets a full buffer keeps its entry on offer
	a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
		wr_valid && !wr_ready |=> wr_valid && $stable(wr_data));

endmodule

/* vlog.f */
source/eth_frame_pkg.sv
source/crc32_pkg.sv
source/crc32_byte.sv
source/stream_fifo.sv
source/eth_frame_classify.sv
source/eth_frame_loop_tx.sv
source/eth_frame_loop.sv
bench/eth_frame_loop_tb.sv
